//--- dfe_ctrl_pkg.sv
// downlink DFE control definitions
// path states, configuration opcodes and output credit sizing

package dfe_ctrl_pkg;

   ////////////////////////////////////////
   // path state machine
   ////////////////////////////////////////
   // ST_HOLD means an output frame waits for a credit
   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_RUN  = 2'd1,
      ST_HOLD = 2'd2
   } path_state_e;

   ////////////////////////////////////////
   // configuration bus
   ////////////////////////////////////////
   typedef enum logic [1:0] {
      CFG_NOP      = 2'd0,
      CFG_SET_DLY  = 2'd1,
      CFG_CLR_LINE = 2'd2
   } cfg_op_e;

   // credits held by the sender after reset
   localparam int CREDIT_INIT = 4;
   localparam int CREDIT_BW   = 3;

endpackage

//--- dfe_types_pkg.sv
// downlink DFE datapath types
// sizing of carriers, antennas and samples, plus the
// frame and delay types shared along the car2ant path

package dfe_types_pkg;

   ////////////////////////////////////////
   // sizing
   ////////////////////////////////////////
   localparam int N_CARRIERS = 2;
   localparam int N_ANTENNAS = 4;
   // one I or Q component
   localparam int PRECISION  = 16;
   // antenna index carried on tuser
   localparam int USR_ID_BW  = $clog2(N_ANTENNAS);
   // delay line depth, in frames
   localparam int MAX_DLY    = 8;
   localparam int DLY_BW     = $clog2(MAX_DLY);
   // carrier sum with growth bits before saturation
   localparam int SUM_BW     = PRECISION + $clog2(N_CARRIERS);

   ////////////////////////////////////////
   // types
   ////////////////////////////////////////
   // complex sample, i in the upper half
   typedef struct packed {
      logic signed [PRECISION-1:0] i;
      logic signed [PRECISION-1:0] q;
   } sample_t;

   // one sample per antenna
   typedef sample_t [N_ANTENNAS-1:0] ant_frame_t;

   typedef logic [DLY_BW-1:0] dly_t;

endpackage

//--- dl_dfe_ant_dly.sv
// per-antenna frame delay
// each antenna keeps a shift line of past combined frames and
// presents the tap picked by its delay register. delays and line
// clear are programmed over the opcode bus while the path is idle

`timescale 1ns/10ps

module dl_dfe_ant_dly (
   input  logic                                clk_1x,
   input  logic                                arst_n,
   input  logic                                cfg_en,
   input  dfe_ctrl_pkg::cfg_op_e               cfg_op,
   input  logic [dfe_types_pkg::USR_ID_BW-1:0] cfg_ant,
   input  dfe_types_pkg::dly_t                 cfg_dly,
   input  logic                                in_valid,
   input  dfe_types_pkg::ant_frame_t           in_frame,
   output logic                                dly_valid,
   output dfe_types_pkg::ant_frame_t           dly_frame
);

   import dfe_types_pkg::*;
   import dfe_ctrl_pkg::*;

   // tap 0 is the newest frame
   sample_t line [N_ANTENNAS][MAX_DLY];
   dly_t    dly  [N_ANTENNAS];
   logic    cfg_set;
   logic    cfg_clr;

   // opcode decode, only while idle
   assign cfg_set = cfg_en && (cfg_op == CFG_SET_DLY);
   assign cfg_clr = cfg_en && (cfg_op == CFG_CLR_LINE);

   ////////////////////////////////////////
   // delay registers
   ////////////////////////////////////////
   always_ff @(posedge clk_1x or negedge arst_n) begin
      if (!arst_n) begin
         for (int a = 0; a < N_ANTENNAS; a++) begin
            dly[a] <= '0;
         end
      end else if (cfg_set) begin
         dly[cfg_ant] <= cfg_dly;
      end
   end

   ////////////////////////////////////////
   // shift lines
   ////////////////////////////////////////
   // empty taps read as zero after reset or a clear
   always_ff @(posedge clk_1x or negedge arst_n) begin
      if (!arst_n) begin
         line <= '{default: '0};
      end else if (cfg_clr) begin
         line <= '{default: '0};
      end else if (in_valid) begin
         for (int a = 0; a < N_ANTENNAS; a++) begin
            line[a][0] <= in_frame[a];
            for (int k = 1; k < MAX_DLY; k++) begin
               line[a][k] <= line[a][k-1];
            end
         end
      end
   end

   always_ff @(posedge clk_1x or negedge arst_n) begin
      if (!arst_n) begin
         dly_valid <= 1'b0;
      end else begin
         dly_valid <= in_valid;
      end
   end

   // tap select per antenna
   always_comb begin
      for (int a = 0; a < N_ANTENNAS; a++) begin
         dly_frame[a] = line[a][dly[a]];
      end
   end

   // config must not land on a frame still moving down the pipe
   a_cfg_quiet: assert property (@(posedge clk_1x) disable iff (!arst_n)
      (cfg_en && (cfg_op != CFG_NOP)) |-> !in_valid)
      else $error("delay config opcode %s while a frame is in flight", cfg_op.name());

endmodule

//--- dl_dfe_ant_s2p.sv
// antenna serial to parallel for one carrier
// collects the serial antenna samples, addressed by tuser,
// into one four-antenna frame and flags each completed frame

`timescale 1ns/10ps

module dl_dfe_ant_s2p (
   input  logic                                clk_1x,
   input  logic                                arst_n,
   input  logic                                enable,
   input  logic                                in_valid,
   input  dfe_types_pkg::sample_t              in_data,
   input  logic [dfe_types_pkg::USR_ID_BW-1:0] in_user,
   output logic                                frame_valid,
   output dfe_types_pkg::ant_frame_t           frame
);

   import dfe_types_pkg::*;

   // sample accepted this cycle
   logic                 store;
   // next antenna index expected on the stream
   logic [USR_ID_BW-1:0] exp_idx;

   // disabled path drops the stream
   assign store = in_valid && enable;

   ////////////////////////////////////////
   // frame assembly
   ////////////////////////////////////////
   always_ff @(posedge clk_1x) begin
      if (store) begin
         frame[in_user] <= in_data;
      end
   end

   // pulse once the last antenna slot is written
   always_ff @(posedge clk_1x or negedge arst_n) begin
      if (!arst_n) begin
         frame_valid <= 1'b0;
      end else begin
         frame_valid <= store && (in_user == USR_ID_BW'(N_ANTENNAS - 1));
      end
   end

   // index tracker, wraps after the last antenna
   always_ff @(posedge clk_1x or negedge arst_n) begin
      if (!arst_n) begin
         exp_idx <= '0;
      end else if (store) begin
         exp_idx <= in_user + 1'b1;
      end
   end

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////
   // antennas arrive 0,1,2,3 with no gap in the index
   a_ant_order: assert property (@(posedge clk_1x) disable iff (!arst_n)
      store |-> (in_user == exp_idx))
      else $error("s2p antenna index %0d, expected %0d", in_user, exp_idx);

endmodule

//--- dl_dfe_car2ant.sv
// downlink DFE carrier to antenna top level
// per carrier s2p, carrier combiner, per-antenna frame delay
// and credit based output flow, all on clk_1x

`timescale 1ns/10ps

module dl_dfe_car2ant (
   input  logic                                                           clk_1x,
   input  logic                                                           arst_n,
   input  logic                                                           stream_enable,
   input  logic [dfe_types_pkg::N_CARRIERS-1:0]                           in_valid,
   input  dfe_types_pkg::sample_t [dfe_types_pkg::N_CARRIERS-1:0]         in_data,
   input  logic [dfe_types_pkg::N_CARRIERS-1:0][dfe_types_pkg::USR_ID_BW-1:0] in_user,
   input  dfe_ctrl_pkg::cfg_op_e                                          cfg_op,
   input  logic [dfe_types_pkg::USR_ID_BW-1:0]                            cfg_ant,
   input  dfe_types_pkg::dly_t                                            cfg_dly,
   input  logic                                                           credit_return,
   output logic                                                           out_valid,
   output dfe_types_pkg::ant_frame_t                                      out_frame,
   output logic                                                           overflow
);

   import dfe_types_pkg::*;

   // s2p to combiner, one frame per carrier
   logic [N_CARRIERS-1:0]              s2p_valid;
   ant_frame_t [N_CARRIERS-1:0]        s2p_frame;
   // combiner to delay
   logic                               cmbn_valid;
   ant_frame_t                         cmbn_frame;
   // delay to output FSM
   logic                               dly_valid;
   ant_frame_t                         dly_frame;
   // control
   logic                               cfg_en;
   logic                               credit_avail;

   ////////////////////////////////////////
   // serial to parallel per carrier
   ////////////////////////////////////////
   for (genvar c = 0; c < N_CARRIERS; c++) begin : g_s2p
      dl_dfe_ant_s2p u_ant_s2p (
         .clk_1x      (clk_1x),
         .arst_n      (arst_n),
         .enable      (stream_enable),
         .in_valid    (in_valid[c]),
         .in_data     (in_data[c]),
         .in_user     (in_user[c]),
         .frame_valid (s2p_valid[c]),
         .frame       (s2p_frame[c])
      );
   end : g_s2p

   ////////////////////////////////////////
   // combine and delay
   ////////////////////////////////////////
   dl_dfe_cmbn u_cmbn (
      .clk_1x     (clk_1x),
      .arst_n     (arst_n),
      .in_valid   (s2p_valid),
      .in_frame   (s2p_frame),
      .cmbn_valid (cmbn_valid),
      .cmbn_frame (cmbn_frame)
   );

   dl_dfe_ant_dly u_ant_dly (
      .clk_1x    (clk_1x),
      .arst_n    (arst_n),
      .cfg_en    (cfg_en),
      .cfg_op    (cfg_op),
      .cfg_ant   (cfg_ant),
      .cfg_dly   (cfg_dly),
      .in_valid  (cmbn_valid),
      .in_frame  (cmbn_frame),
      .dly_valid (dly_valid),
      .dly_frame (dly_frame)
   );

   ////////////////////////////////////////
   // output flow
   ////////////////////////////////////////
   dl_dfe_flow_fsm u_flow_fsm (
      .clk_1x        (clk_1x),
      .arst_n        (arst_n),
      .stream_enable (stream_enable),
      .dly_valid     (dly_valid),
      .dly_frame     (dly_frame),
      .credit_avail  (credit_avail),
      .cfg_en        (cfg_en),
      .out_valid     (out_valid),
      .out_frame     (out_frame),
      .overflow      (overflow)
   );

   // out_valid spends one credit
   dl_dfe_credit_cnt u_credit_cnt (
      .clk_1x        (clk_1x),
      .arst_n        (arst_n),
      .consume       (out_valid),
      .credit_return (credit_return),
      .credit_avail  (credit_avail)
   );

endmodule

//--- dl_dfe_cmbn.sv
// carrier combiner
// adds the carrier frames antenna by antenna, with I and Q
// saturated on their own to the signed sample range

`timescale 1ns/10ps

module dl_dfe_cmbn (
   input  logic                                                        clk_1x,
   input  logic                                                        arst_n,
   input  logic [dfe_types_pkg::N_CARRIERS-1:0]                        in_valid,
   input  dfe_types_pkg::ant_frame_t [dfe_types_pkg::N_CARRIERS-1:0]   in_frame,
   output logic                                                        cmbn_valid,
   output dfe_types_pkg::ant_frame_t                                   cmbn_frame
);

   import dfe_types_pkg::*;

   // full width sums per antenna
   logic signed [SUM_BW-1:0] sum_i [N_ANTENNAS];
   logic signed [SUM_BW-1:0] sum_q [N_ANTENNAS];
   ant_frame_t               sat_frame;

   // clamp to the signed range when the growth bits disagree
   function automatic logic signed [PRECISION-1:0] sat_trunc(
      input logic signed [SUM_BW-1:0] v);
      logic [SUM_BW-PRECISION:0] top;
      top = v[SUM_BW-1:PRECISION-1];
      if ((&top) || !(|top))
         return v[PRECISION-1:0];
      if (v[SUM_BW-1])
         return {1'b1, {(PRECISION-1){1'b0}}};
      return {1'b0, {(PRECISION-1){1'b1}}};
   endfunction

   ////////////////////////////////////////
   // sum and saturate
   ////////////////////////////////////////
   always_comb begin
      for (int a = 0; a < N_ANTENNAS; a++) begin
         sum_i[a] = '0;
         sum_q[a] = '0;
         for (int c = 0; c < N_CARRIERS; c++) begin
            // sign extend before the add
            sum_i[a] = sum_i[a] + SUM_BW'(in_frame[c][a].i);
            sum_q[a] = sum_q[a] + SUM_BW'(in_frame[c][a].q);
         end
         sat_frame[a].i = sat_trunc(sum_i[a]);
         sat_frame[a].q = sat_trunc(sum_q[a]);
      end
   end

   // output stage
   always_ff @(posedge clk_1x or negedge arst_n) begin
      if (!arst_n) begin
         cmbn_valid <= 1'b0;
      end else begin
         cmbn_valid <= &in_valid;
      end
   end

   always_ff @(posedge clk_1x) begin
      if (&in_valid) begin
         cmbn_frame <= sat_frame;
      end
   end

   // carriers run in lockstep, so every s2p flags the same cycle
   a_car_lockstep: assert property (@(posedge clk_1x) disable iff (!arst_n)
      (in_valid == '0) || (&in_valid))
      else $error("combiner carriers out of step, valid %b", in_valid);

endmodule

//--- dl_dfe_credit_cnt.sv
// output credit counter
// tracks the credits the sender holds, one spent per output
// frame and one returned per credit_return pulse

`timescale 1ns/10ps

module dl_dfe_credit_cnt (
   input  logic clk_1x,
   input  logic arst_n,
   input  logic consume,
   input  logic credit_return,
   output logic credit_avail
);

   import dfe_ctrl_pkg::*;

   logic [CREDIT_BW-1:0] count;
   logic [CREDIT_BW-1:0] count_nxt;

   // spend and return together cancel out
   always_comb begin
      count_nxt = count;
      if (consume && !credit_return)
         count_nxt = count - 1'b1;
      else if (credit_return && !consume)
         count_nxt = count + 1'b1;
   end

   always_ff @(posedge clk_1x or negedge arst_n) begin
      if (!arst_n) begin
         count <= CREDIT_BW'(CREDIT_INIT);
      end else begin
         count <= count_nxt;
      end
   end

   // credit left once this cycle's send has retired
   assign credit_avail = (count_nxt != '0);

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////
   a_no_underflow: assert property (@(posedge clk_1x) disable iff (!arst_n)
      consume |-> (count != '0))
      else $error("output frame sent with no credit");

   a_no_excess: assert property (@(posedge clk_1x) disable iff (!arst_n)
      (credit_return && !consume) |-> (count < CREDIT_BW'(CREDIT_INIT)))
      else $error("credit returned beyond the initial pool");

endmodule

//--- dl_dfe_flow_fsm.sv
// path flow state machine
// owns the output holding register, sends each delayed frame
// when a credit is free, waits in ST_HOLD otherwise, and flags
// frames lost while one is still held

`timescale 1ns/10ps

module dl_dfe_flow_fsm (
   input  logic                      clk_1x,
   input  logic                      arst_n,
   input  logic                      stream_enable,
   input  logic                      dly_valid,
   input  dfe_types_pkg::ant_frame_t dly_frame,
   input  logic                      credit_avail,
   output logic                      cfg_en,
   output logic                      out_valid,
   output dfe_types_pkg::ant_frame_t out_frame,
   output logic                      overflow
);

   import dfe_ctrl_pkg::*;

   path_state_e state;
   path_state_e state_nxt;
   // new frame taken into the holding register
   logic        accept;

   // holding register is free outside ST_HOLD
   assign accept = dly_valid && (state != ST_HOLD);
   // config bus only while idle
   assign cfg_en = (state == ST_IDLE);

   ////////////////////////////////////////
   // next state
   ////////////////////////////////////////
   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (accept && !credit_avail)
               state_nxt = ST_HOLD;
            else if (stream_enable)
               state_nxt = ST_RUN;
         end
         ST_RUN: begin
            if (accept && !credit_avail)
               state_nxt = ST_HOLD;
            else if (!stream_enable)
               state_nxt = ST_IDLE;
         end
         // leave once the held frame goes out
         ST_HOLD: begin
            if (credit_avail)
               state_nxt = stream_enable ? ST_RUN : ST_IDLE;
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   ////////////////////////////////////////
   // state, send pulse and overflow
   ////////////////////////////////////////
   always_ff @(posedge clk_1x or negedge arst_n) begin
      if (!arst_n) begin
         state     <= ST_IDLE;
         out_valid <= 1'b0;
         overflow  <= 1'b0;
      end else begin
         state     <= state_nxt;
         // one cycle pulse, also consumes the credit
         out_valid <= (accept || (state == ST_HOLD)) && credit_avail;
         // sticky until reset
         if (dly_valid && (state == ST_HOLD))
            overflow <= 1'b1;
      end
   end

   // holding register
   always_ff @(posedge clk_1x) begin
      if (accept) begin
         out_frame <= dly_frame;
      end
   end

endmodule

//--- flist.f
dfe_types_pkg.sv
dfe_ctrl_pkg.sv
dl_dfe_ant_s2p.sv
dl_dfe_cmbn.sv
dl_dfe_ant_dly.sv
dl_dfe_flow_fsm.sv
dl_dfe_credit_cnt.sv
dl_dfe_car2ant.sv
tb_dl_dfe_car2ant.sv

//--- run_sim.sh
#!/bin/sh
# compile the car2ant path and its testbench with Verilator, run it,
# and decide pass or fail from the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_dl_dfe_car2ant \
   -Mdir obj_dir \
   -f flist.f
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

out=$(./obj_dir/Vtb_dl_dfe_car2ant)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- tb_dl_dfe_car2ant.sv
// testbench for the downlink DFE carrier to antenna path
// drives two lockstep carrier streams, models the saturating
// sum and per-antenna delay, and checks output frames, credit
// stall and the sticky overflow flag

`timescale 1ns/10ps

module tb_dl_dfe_car2ant;

   import dfe_types_pkg::*;
   import dfe_ctrl_pkg::*;

   // cycles any single wait may take
   localparam int WAIT_LIMIT = 40;

   logic                                  clk_1x;
   logic                                  arst_n;
   logic                                  stream_enable;
   logic [N_CARRIERS-1:0]                 in_valid;
   sample_t [N_CARRIERS-1:0]              in_data;
   logic [N_CARRIERS-1:0][USR_ID_BW-1:0]  in_user;
   cfg_op_e                               cfg_op;
   logic [USR_ID_BW-1:0]                  cfg_ant;
   dly_t                                  cfg_dly;
   logic                                  credit_return;
   logic                                  out_valid;
   ant_frame_t                            out_frame;
   logic                                  overflow;

   // reference model state with tap 0 newest
   sample_t     hist [N_ANTENNAS][MAX_DLY];
   dly_t        mdly [N_ANTENNAS];
   logic [31:0] lcg_state = 32'h5ac3_6f8e;
   int          err_cnt = 0;
   int          chk_cnt = 0;
   int          test_cnt = 0;

   dl_dfe_car2ant dl_dfe_car2ant_inst (
      .clk_1x        (clk_1x),
      .arst_n        (arst_n),
      .stream_enable (stream_enable),
      .in_valid      (in_valid),
      .in_data       (in_data),
      .in_user       (in_user),
      .cfg_op        (cfg_op),
      .cfg_ant       (cfg_ant),
      .cfg_dly       (cfg_dly),
      .credit_return (credit_return),
      .out_valid     (out_valid),
      .out_frame     (out_frame),
      .overflow      (overflow)
   );

   initial begin
      clk_1x = 1'b0;
      forever #20 clk_1x = ~clk_1x;
   end

   ////////////////////////////////////////
   // random data and reference model
   ////////////////////////////////////////
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic ant_frame_t rand_frame();
      ant_frame_t f;
      for (int a = 0; a < N_ANTENNAS; a++) begin
         f[a] = sample_t'(lcg_next());
      end
      return f;
   endfunction

   // clip to signed 16 bit
   function automatic logic signed [PRECISION-1:0] clamp16(input int v);
      if (v > 32767)
         return 16'sh7fff;
      if (v < -32768)
         return 16'sh8000;
      return 16'(v);
   endfunction

   // combined frame enters the history and the expected output comes back
   task automatic model_push(input ant_frame_t c0, input ant_frame_t c1,
                             output ant_frame_t want);
      for (int a = 0; a < N_ANTENNAS; a++) begin
         for (int k = MAX_DLY - 1; k > 0; k--) begin
            hist[a][k] = hist[a][k-1];
         end
         hist[a][0].i = clamp16(int'(c0[a].i) + int'(c1[a].i));
         hist[a][0].q = clamp16(int'(c0[a].q) + int'(c1[a].q));
         want[a] = hist[a][mdly[a]];
      end
   endtask

   task automatic model_clear();
      for (int a = 0; a < N_ANTENNAS; a++) begin
         for (int k = 0; k < MAX_DLY; k++) begin
            hist[a][k] = '0;
         end
      end
   endtask

   ////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////
   task automatic compare_frame(input ant_frame_t got, input ant_frame_t want,
                                input string what);
      chk_cnt++;
      if (got !== want) begin
         $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, want);
         err_cnt++;
      end
   endtask

   task automatic compare_bit(input logic got, input logic want, input string what);
      chk_cnt++;
      if (got !== want) begin
         $display("FAILED at %0t: %s, got %b expected %b", $time, what, got, want);
         err_cnt++;
      end
   endtask

   // out_valid must stay low for the whole window
   task automatic no_output(input int cycles, input string what);
      for (int n = 0; n < cycles; n++) begin
         @(negedge clk_1x);
         if (out_valid) begin
            $display("unexpected output frame at %0t during %s", $time, what);
            err_cnt++;
         end
      end
   endtask

   // waits from the current falling edge and checks the value first
   task automatic wait_out(output int waited, output bit ok);
      waited = 0;
      while (!out_valid && waited < WAIT_LIMIT) begin
         @(negedge clk_1x);
         waited++;
      end
      ok = out_valid;
      if (!ok) begin
         $display("timeout at %0t: no out_valid within %0d cycles", $time, WAIT_LIMIT);
         err_cnt++;
      end
   endtask

   // state as seen from outside where idle and hold send nothing
   task automatic compare_state(input path_state_e want, input int cycles,
                                input string what);
      int waited;
      bit ok;
      chk_cnt++;
      case (want)
         ST_IDLE, ST_HOLD: no_output(cycles, {what, " in ", want.name()});
         default:          wait_out(waited, ok);
      endcase
   endtask

   ////////////////////////////////////////
   // stimulus helpers
   ////////////////////////////////////////
   task automatic apply_reset();
      arst_n        = 1'b0;
      stream_enable = 1'b0;
      in_valid      = '0;
      in_data       = '0;
      in_user       = '0;
      cfg_op        = CFG_NOP;
      cfg_ant       = '0;
      cfg_dly       = '0;
      credit_return = 1'b0;
      repeat (3) @(negedge clk_1x);
      arst_n = 1'b1;
      @(negedge clk_1x);
      model_clear();
      for (int a = 0; a < N_ANTENNAS; a++) begin
         mdly[a] = '0;
      end
   endtask

   // antennas 0 to 3 on both carriers
   task automatic send_frame(input ant_frame_t c0, input ant_frame_t c1);
      for (int a = 0; a < N_ANTENNAS; a++) begin
         in_valid   = '1;
         in_data[0] = c0[a];
         in_data[1] = c1[a];
         in_user[0] = USR_ID_BW'(a);
         in_user[1] = USR_ID_BW'(a);
         @(negedge clk_1x);
      end
      in_valid = '0;
   endtask

   task automatic return_credit();
      credit_return = 1'b1;
      @(negedge clk_1x);
      credit_return = 1'b0;
   endtask

   task automatic write_cfg(input cfg_op_e op, input int ant, input int dly);
      cfg_op  = op;
      cfg_ant = USR_ID_BW'(ant);
      cfg_dly = DLY_BW'(dly);
      @(negedge clk_1x);
      cfg_op = CFG_NOP;
      if (op == CFG_SET_DLY)
         mdly[ant] = DLY_BW'(dly);
      else if (op == CFG_CLR_LINE)
         model_clear();
   endtask

   // one frame through the path where lat 0 skips the latency check
   task automatic run_frame(input ant_frame_t c0, input ant_frame_t c1,
                            input bit give_back, input int lat, input string what);
      ant_frame_t want;
      int         waited;
      bit         ok;
      model_push(c0, c1, want);
      send_frame(c0, c1);
      wait_out(waited, ok);
      if (ok) begin
         compare_frame(out_frame, want, what);
         // index 3 was driven one cycle before the wait began
         if (lat > 0 && waited + 1 != lat) begin
            $display("FAILED at %0t: %s latency %0d expected %0d", $time, what,
                     waited + 1, lat);
            err_cnt++;
         end
         if (give_back)
            return_credit();
      end
   endtask

   task automatic finish_test(input string name, input int err_before);
      test_cnt++;
      $display("test %s done, %0d errors", name, err_cnt - err_before);
   endtask

   ////////////////////////////////////////
   // tests
   ////////////////////////////////////////
   task automatic test_reset_idle();
      int e0;
      e0 = err_cnt;
      apply_reset();
      compare_bit(out_valid, 1'b0, "out_valid after reset");
      compare_bit(overflow, 1'b0, "overflow after reset");
      // samples vanish while the stream is disabled
      send_frame(rand_frame(), rand_frame());
      compare_state(ST_IDLE, 12, "disabled stream");
      finish_test("reset_idle", e0);
   endtask

   task automatic test_pass_sum();
      int e0;
      e0 = err_cnt;
      apply_reset();
      stream_enable = 1'b1;
      for (int n = 0; n < 6; n++) begin
         run_frame(rand_frame(), rand_frame(), 1'b1, 4, "pass-through sum");
      end
      finish_test("pass_sum", e0);
   endtask

   task automatic test_saturation();
      int         e0;
      ant_frame_t c0;
      ant_frame_t c1;
      e0 = err_cnt;
      apply_reset();
      stream_enable = 1'b1;
      // ant3 down to ant0 with i in the upper half of each word
      c0 = {32'h7fff_8000, 32'h7000_9000, 32'h8000_8000, 32'h7fff_7fff};
      c1 = {32'h0000_ffff, 32'h1000_9000, 32'hffff_8000, 32'h0001_7fff};
      run_frame(c0, c1, 1'b1, 0, "saturated sum");
      run_frame(c1, c1, 1'b1, 0, "mixed sum");
      finish_test("saturation", e0);
   endtask

   task automatic test_delay_cfg();
      int e0;
      e0 = err_cnt;
      apply_reset();
      write_cfg(CFG_SET_DLY, 0, 0);
      write_cfg(CFG_SET_DLY, 1, 1);
      write_cfg(CFG_SET_DLY, 2, 3);
      write_cfg(CFG_SET_DLY, 3, 7);
      stream_enable = 1'b1;
      for (int n = 0; n < 3; n++) begin
         run_frame(rand_frame(), rand_frame(), 1'b1, 0, "delayed frame");
      end
      // back to idle so the clear is taken
      stream_enable = 1'b0;
      repeat (2) @(negedge clk_1x);
      write_cfg(CFG_CLR_LINE, 0, 0);
      stream_enable = 1'b1;
      for (int n = 0; n < 9; n++) begin
         run_frame(rand_frame(), rand_frame(), 1'b1, 0, "frame after clear");
      end
      finish_test("delay_cfg", e0);
   endtask

   task automatic test_credit_flow();
      int e0;
      e0 = err_cnt;
      apply_reset();
      stream_enable = 1'b1;
      // spend the whole credit pool
      for (int n = 0; n < CREDIT_INIT; n++) begin
         run_frame(rand_frame(), rand_frame(), 1'b0, 0, "credit frame");
      end
      for (int n = 0; n < 2; n++) begin
         ant_frame_t c0;
         ant_frame_t c1;
         ant_frame_t want;
         c0 = rand_frame();
         c1 = rand_frame();
         model_push(c0, c1, want);
         send_frame(c0, c1);
         compare_state(ST_HOLD, 12, "no credit");
         return_credit();
         // one credit moves the path on to ST_RUN with the held frame out
         compare_state(ST_RUN, 0, "credit returned");
         if (out_valid)
            compare_frame(out_frame, want, "frame released by one credit");
      end
      finish_test("credit_flow", e0);
   endtask

   task automatic test_overflow();
      int         e0;
      int         waited;
      bit         ok;
      ant_frame_t c0;
      ant_frame_t c1;
      ant_frame_t held;
      ant_frame_t lost;
      e0 = err_cnt;
      apply_reset();
      stream_enable = 1'b1;
      for (int n = 0; n < CREDIT_INIT; n++) begin
         run_frame(rand_frame(), rand_frame(), 1'b0, 0, "pool frame");
      end
      c0 = rand_frame();
      c1 = rand_frame();
      model_push(c0, c1, held);
      send_frame(c0, c1);
      // frame settles in the holding register with no credit left
      no_output(4, "held frame");
      compare_bit(overflow, 1'b0, "overflow with one frame held");
      // second frame finds the holding register busy
      c0 = rand_frame();
      c1 = rand_frame();
      model_push(c0, c1, lost);
      send_frame(c0, c1);
      no_output(6, "dropped frame");
      compare_bit(overflow, 1'b1, "overflow after drop");
      return_credit();
      wait_out(waited, ok);
      if (ok)
         compare_frame(out_frame, held, "held frame");
      return_credit();
      no_output(12, "credit with nothing held");
      compare_bit(overflow, 1'b1, "overflow sticky");
      finish_test("overflow", e0);
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////
   initial begin
      apply_reset();
      test_reset_idle();
      test_pass_sum();
      test_saturation();
      test_delay_cfg();
      test_credit_flow();
      test_overflow();
      $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
